//--- filelist.f
src/trace_pkg.sv
src/stage_tag_tracker.sv
src/trace_record_store.sv
src/trace_config_regs.sv
src/retire_reporter.sv
src/pipeline_trace_top.sv
test/trace_assertions.sv
test/trace_checker.sv
test/pipeline_trace_tb.sv

//--- Makefile
SRCS := $(shell cat filelist.f)
BIN  := obj_dir/Vpipeline_trace_tb

.PHONY: all run clean

all: $(BIN)

$(BIN): filelist.f $(SRCS)
	verilator --binary --timing --assert --top-module pipeline_trace_tb -f filelist.f

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'all tests passed'

clean:
	rm -rf obj_dir

//--- test/pipeline_trace_tb.sv
/* Trace unit testbench with clock, reset, stimulus table,
   watchdog and closing counts */

`timescale 1ns/1ps
`default_nettype none

module pipeline_trace_tb;

    localparam int ID_W = 4;
    localparam int NUM_TESTS = 9;
    localparam logic [31:0] WIN_LO = 32'h4000_0000; // PC window of the window tests
    localparam logic [31:0] WIN_HI = 32'hc000_0000;

    logic        clk = 1'b0;
    logic        rst_n = 1'b0;
    logic        stall = 1'b0;
    logic [31:0] fetch_pc = '0, decode_instr = '0, exec_result = '0, mem_addr = '0;
    logic [31:0] wb_data = '0;
    logic [4:0]  wb_rd = '0;
    logic        cfg_wr = 1'b0;
    logic [1:0]  cfg_addr = '0;
    logic [31:0] cfg_wdata = '0;
    logic        report_valid;
    logic [ID_W-1:0] report_tag;
    logic [31:0] report_pc, report_instr, report_result, report_addr, report_data;
    logic [4:0]  report_rd;
    logic [3:0]  report_stalls;
    logic [31:0] report_cycle, retired_count;

    integer seed = 32'hc0f1_ec38;

    // Stimulus table, one entry per test
    string       t_name [NUM_TESTS];
    bit          t_cfg [NUM_TESTS];     // Config write in the first cycle
    logic [1:0]  t_addr [NUM_TESTS];
    logic [31:0] t_wdata [NUM_TESTS];
    int          t_cycles [NUM_TESTS];
    int          t_stall_at [NUM_TESTS];
    int          t_stall_len [NUM_TESTS];
    bit          t_reset [NUM_TESTS];   // Reset over the first 4 cycles

    pipeline_trace_top #(.ID_W(ID_W)) pipeline_trace_top_i (.*);

    trace_checker #(.ID_W(ID_W)) trace_checker_i (.*);

    bind pipeline_trace_top trace_assertions #(.ID_W(ID_W)) trace_assertions_i (
        .clk(clk), .rst_n(rst_n), .stall(stall), .fetch_valid(fetch_valid),
        .decode_valid(decode_valid), .exec_valid(exec_valid), .mem_valid(mem_valid),
        .wb_valid(wb_valid), .decode_tag(decode_tag), .report_valid(report_valid)
    );

    // Checker mismatches plus failed assertions
    function automatic int total_errors();
        return trace_checker_i.err_count
               + pipeline_trace_top_i.trace_assertions_i.fail_count;
    endfunction

    task automatic set_row(input int i, input string name, input bit cfg,
                           input logic [1:0] addr, input logic [31:0] wdata,
                           input int cycles, input int at, input int len, input bit rst);
        t_name[i] = name;
        t_cfg[i] = cfg;
        t_addr[i] = addr;
        t_wdata[i] = wdata;
        t_cycles[i] = cycles;
        t_stall_at[i] = at;
        t_stall_len[i] = len;
        t_reset[i] = rst;
    endtask

    task automatic load_table();
        set_row(0, "no stall, full window", 1'b1, 2'd0, 32'h1, 30, 0, 0, 1'b0);
        set_row(1, "short stall", 1'b0, 2'd0, 32'h0, 30, 5, 4, 1'b0);
        set_row(2, "stall saturates", 1'b0, 2'd0, 32'h0, 40, 3, 20, 1'b0);
        set_row(3, "trace disabled", 1'b1, 2'd0, 32'h0, 20, 6, 2, 1'b0);
        set_row(4, "trace enabled again", 1'b1, 2'd0, 32'h1, 10, 0, 0, 1'b0);
        set_row(5, "window low bound", 1'b1, 2'd1, WIN_LO, 10, 0, 0, 1'b0);
        set_row(6, "window high bound", 1'b1, 2'd2, WIN_HI, 40, 12, 3, 1'b0);
        set_row(7, "mid-run reset", 1'b0, 2'd0, 32'h0, 30, 10, 5, 1'b1);
        set_row(8, "after reset", 1'b1, 2'd0, 32'h1, 30, 8, 2, 1'b0);
    endtask

    // Fresh random stage data each cycle
    task automatic drive_data();
        logic [31:0] r;
        r = $random(seed);
        case (r[7:5])
            3'd0: fetch_pc = WIN_LO;        // Window edges and their neighbors
            3'd1: fetch_pc = WIN_HI;
            3'd2: fetch_pc = WIN_LO - 1;
            3'd3: fetch_pc = WIN_HI + 1;
            default: fetch_pc = $random(seed);
        endcase
        decode_instr = $random(seed);
        exec_result = $random(seed);
        mem_addr = $random(seed);
        wb_data = $random(seed);
        wb_rd = r[4:0];
    endtask

    initial begin
        forever #4 clk = ~clk;   // 8 ns period
    end

    ////////////////////
    // Watchdog
    ////////////////////
    initial begin
        int total;
        total = 0;
        load_table();
        for (int i = 0; i < NUM_TESTS; i++) total += t_cycles[i];
        #((total + 50) * 8);
        $display("Timeout, run did not finish in %0d cycles", total + 50);
        $display("tests failed");
        $finish;
    end

    initial begin
        int errs_before, reps_before;
        load_table();
        repeat (3) @(posedge clk);   // Reset low on the first 4 edges
        for (int t = 0; t < NUM_TESTS; t++) begin
            errs_before = total_errors();
            reps_before = trace_checker_i.report_count;
            for (int i = 0; i < t_cycles[t]; i++) begin
                @(posedge clk);
                #1;
                rst_n = !(t_reset[t] && i < 4);
                stall = (i >= t_stall_at[t]) && (i < t_stall_at[t] + t_stall_len[t]);
                cfg_wr = t_cfg[t] && (i == 0);
                cfg_addr = t_addr[t];
                cfg_wdata = t_wdata[t];
                drive_data();
            end
            $display("test %0d %s: %0d reports, %0d errors", t, t_name[t],
                     trace_checker_i.report_count - reps_before,
                     total_errors() - errs_before);
        end
        // Drain in-flight instructions
        repeat (10) begin
            @(posedge clk);
            #1;
            stall = 1'b0;
            cfg_wr = 1'b0;
            drive_data();
        end
        @(posedge clk);
        #1;
        $display("tests run %0d, reports checked %0d, errors %0d", NUM_TESTS,
                 trace_checker_i.report_count, total_errors());
        if (total_errors() == 0 && trace_checker_i.report_count > 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/trace_checker.sv
/* Reference model of tracker, capture, filter and counters;
   compares every report strobe and the retire count */

`timescale 1ns/1ps
`default_nettype none

module trace_checker #(
    parameter int ID_W = 4
) (
    input wire logic                             clk,
    input wire logic                             rst_n,
    input wire logic                             stall,
    input wire logic [trace_pkg::XLEN-1:0]       fetch_pc,
    input wire logic [trace_pkg::XLEN-1:0]       decode_instr,
    input wire logic [trace_pkg::XLEN-1:0]       exec_result,
    input wire logic [trace_pkg::XLEN-1:0]       mem_addr,
    input wire logic [trace_pkg::XLEN-1:0]       wb_data,
    input wire logic [trace_pkg::RD_W-1:0]       wb_rd,
    input wire logic                             cfg_wr,
    input wire logic [trace_pkg::CFG_ADDR_W-1:0] cfg_addr,
    input wire logic [trace_pkg::XLEN-1:0]       cfg_wdata,
    input wire logic                             report_valid,
    input wire logic [ID_W-1:0]                  report_tag,
    input wire logic [trace_pkg::XLEN-1:0]       report_pc,
    input wire logic [trace_pkg::XLEN-1:0]       report_instr,
    input wire logic [trace_pkg::XLEN-1:0]       report_result,
    input wire logic [trace_pkg::XLEN-1:0]       report_addr,
    input wire logic [trace_pkg::XLEN-1:0]       report_data,
    input wire logic [trace_pkg::RD_W-1:0]       report_rd,
    input wire logic [trace_pkg::STALL_W-1:0]    report_stalls,
    input wire logic [trace_pkg::XLEN-1:0]       report_cycle,
    input wire logic [trace_pkg::XLEN-1:0]       retired_count
);

    localparam int DEPTH = 2**ID_W;

    int err_count = 0;
    int report_count = 0;
    bit live = 1'b0;                 // Set once the first reset is seen

    // Model pipeline, config and records
    bit f_v, d_v, e_v, m_v, w_v;
    logic [ID_W-1:0] f_t, d_t, e_t, m_t, w_t, n_tag;
    int dcnt, cycle, retired;
    bit en;
    logic [31:0] lo, hi;
    logic [31:0] r_pc [DEPTH];
    logic [31:0] r_instr [DEPTH];
    logic [31:0] r_result [DEPTH];
    logic [31:0] r_addr [DEPTH];
    int r_stalls [DEPTH];
    // Expected report, pending for the next edge
    bit x_v;
    logic [31:0] x_tag, x_pc, x_instr, x_result, x_addr, x_data, x_rd, x_stalls, x_cycle;

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            err_count++;
            $display("[FAIL] %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    always @(posedge clk) begin
        int cnt_now;
        // Report strobe launched by the previous edge
        if (live) begin
            if (report_valid && !x_v) begin
                err_count++;
                $display("Unexpected report strobe with tag %0d at %0t", report_tag, $time);
            end else if (!report_valid && x_v) begin
                err_count++;
                $display("Missing report strobe for tag %0d at %0t", x_tag, $time);
            end else if (report_valid) begin
                report_count++;
                compare_field("report_tag", 32'(report_tag), x_tag);
                compare_field("report_pc", report_pc, x_pc);
                compare_field("report_instr", report_instr, x_instr);
                compare_field("report_result", report_result, x_result);
                compare_field("report_addr", report_addr, x_addr);
                compare_field("report_data", report_data, x_data);
                compare_field("report_rd", 32'(report_rd), x_rd);
                compare_field("report_stalls", 32'(report_stalls), x_stalls);
                compare_field("report_cycle", report_cycle, x_cycle);
            end
            compare_field("retired_count", retired_count, 32'(retired));
        end
        x_v = 1'b0;
        if (!rst_n) begin
            live = 1'b1;
            {f_v, d_v, e_v, m_v, w_v} = '0;
            {f_t, d_t, e_t, m_t, w_t, n_tag} = '0;
            dcnt = 0;
            cycle = 0;
            retired = 0;
            en = 1'b0;
            lo = '0;
            hi = '1;
        end else if (live) begin
            // Retirement reads records before this edge's captures
            if (w_v) begin
                retired++;
                if (en && r_pc[w_t] >= lo && r_pc[w_t] <= hi) begin
                    x_v = 1'b1;
                    x_tag = 32'(w_t);
                    x_pc = r_pc[w_t];
                    x_instr = r_instr[w_t];
                    x_result = r_result[w_t];
                    x_addr = r_addr[w_t];
                    x_data = wb_data;
                    x_rd = 32'(wb_rd);
                    x_stalls = 32'(r_stalls[w_t]);
                    x_cycle = 32'(cycle);
                end
            end
            // Stage captures, held stages overwrite
            if (f_v) r_pc[f_t] = fetch_pc;
            cnt_now = (stall && dcnt < 15) ? dcnt + 1 : dcnt; // Saturates at 15
            if (d_v) begin
                r_instr[d_t] = decode_instr;
                r_stalls[d_t] = cnt_now;
            end
            if (e_v) r_result[e_t] = exec_result;
            if (m_v) r_addr[m_t] = mem_addr;
            dcnt = !stall ? 0 : (d_v ? cnt_now : dcnt);
            // Advance, back stages first
            w_v = m_v;
            w_t = m_t;
            m_v = e_v;
            m_t = e_t;
            e_v = d_v && !stall;   // Bubble under stall
            e_t = d_t;
            if (!stall) begin
                d_v = f_v;
                d_t = f_t;
                f_v = 1'b1;
                f_t = n_tag;
                n_tag = n_tag + 1'b1;
            end
            // Config writes land for the next cycle
            if (cfg_wr) begin
                if (cfg_addr == 2'd0) en = cfg_wdata[0];
                else if (cfg_addr == 2'd1) lo = cfg_wdata;
                else if (cfg_addr == 2'd2) hi = cfg_wdata;
            end
            cycle++;
        end
    end

endmodule

`default_nettype wire

//--- test/trace_assertions.sv
/* Bound timing assertions for the tag tracker
   and the retire report strobe */

`timescale 1ns/1ps
`default_nettype none

module trace_assertions #(
    parameter int ID_W = 4
) (
    input wire logic            clk,
    input wire logic            rst_n,
    input wire logic            stall,
    input wire logic            fetch_valid,
    input wire logic            decode_valid,
    input wire logic            exec_valid,
    input wire logic            mem_valid,
    input wire logic            wb_valid,
    input wire logic [ID_W-1:0] decode_tag,
    input wire logic            report_valid
);

    int fail_count = 0; // Assertion failures so far

    // Execute gets a bubble behind a held decode
    exec_bubble_a: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> !exec_valid)
        else begin
            fail_count++;
            $error("execute valid high after a stall cycle");
        end

    // Decode holds its instruction while stalled
    decode_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> ($stable(decode_tag) && $stable(decode_valid)))
        else begin
            fail_count++;
            $error("decode tag or valid moved under stall");
        end

    report_after_wb_a: assert property (@(posedge clk) disable iff (!rst_n)
        report_valid |-> $past(wb_valid))
        else begin
            fail_count++;
            $error("report strobe without write-back in the cycle before");
        end

    ////////////////////
    // Reset behavior
    ////////////////////
    reset_quiet_a: assert property (@(posedge clk)
        !rst_n |=> !(fetch_valid || decode_valid || exec_valid || mem_valid
                     || wb_valid || report_valid))
        else begin
            fail_count++;
            $error("control output high during reset");
        end

endmodule

`default_nettype wire

//--- src/pipeline_trace_top.sv
/* Trace unit top level wiring tracker, record store,
   configuration registers and retire reporter */

`timescale 1ns/1ps
`default_nettype none

module pipeline_trace_top #(
    parameter int ID_W = 4
) (
    input  wire logic                               clk,
    input  wire logic                               rst_n,
    // CPU pipeline taps
    input  wire logic                               stall,
    input  wire logic [trace_pkg::XLEN-1:0]         fetch_pc,
    input  wire logic [trace_pkg::XLEN-1:0]         decode_instr,
    input  wire logic [trace_pkg::XLEN-1:0]         exec_result,
    input  wire logic [trace_pkg::XLEN-1:0]         mem_addr,
    input  wire logic [trace_pkg::XLEN-1:0]         wb_data,
    input  wire logic [trace_pkg::RD_W-1:0]         wb_rd,
    // Configuration write port
    input  wire logic                               cfg_wr,
    input  wire logic [trace_pkg::CFG_ADDR_W-1:0]   cfg_addr,
    input  wire logic [trace_pkg::XLEN-1:0]         cfg_wdata,
    // Retire reports
    output logic                                    report_valid,
    output logic      [ID_W-1:0]                    report_tag,
    output logic      [trace_pkg::XLEN-1:0]         report_pc,
    output logic      [trace_pkg::XLEN-1:0]         report_instr,
    output logic      [trace_pkg::XLEN-1:0]         report_result,
    output logic      [trace_pkg::XLEN-1:0]         report_addr,
    output logic      [trace_pkg::XLEN-1:0]         report_data,
    output logic      [trace_pkg::RD_W-1:0]         report_rd,
    output logic      [trace_pkg::STALL_W-1:0]      report_stalls,
    output logic      [trace_pkg::XLEN-1:0]         report_cycle,
    output logic      [trace_pkg::XLEN-1:0]         retired_count
);

    // Tracker to store and reporter
    logic            fetch_valid, decode_valid, exec_valid, mem_valid, wb_valid;
    logic [ID_W-1:0] fetch_tag, decode_tag, exec_tag, mem_tag, wb_tag;

    // Store to reporter
    logic [trace_pkg::XLEN-1:0]    rec_pc, rec_instr, rec_result, rec_addr;
    logic [trace_pkg::STALL_W-1:0] rec_stalls;

    // Config to reporter
    logic                       trace_en;
    logic [trace_pkg::XLEN-1:0] pc_lo, pc_hi;

    stage_tag_tracker #(.ID_W(ID_W)) stage_tag_tracker_i (
        .clk, .rst_n, .stall,
        .fetch_valid, .decode_valid, .exec_valid, .mem_valid, .wb_valid,
        .fetch_tag, .decode_tag, .exec_tag, .mem_tag, .wb_tag
    );

    trace_record_store #(.ID_W(ID_W)) trace_record_store_i (
        .clk, .rst_n, .stall,
        .fetch_valid, .decode_valid, .exec_valid, .mem_valid, .wb_valid,
        .fetch_tag, .decode_tag, .exec_tag, .mem_tag, .wb_tag,
        .fetch_pc, .decode_instr, .exec_result, .mem_addr,
        .rec_pc, .rec_instr, .rec_result, .rec_addr, .rec_stalls
    );

    trace_config_regs trace_config_regs_i (
        .clk, .rst_n, .cfg_wr, .cfg_addr, .cfg_wdata,
        .trace_en, .pc_lo, .pc_hi
    );

    retire_reporter #(.ID_W(ID_W)) retire_reporter_i (
        .clk, .rst_n, .wb_valid, .wb_tag,
        .rec_pc, .rec_instr, .rec_result, .rec_addr, .rec_stalls,
        .wb_data, .wb_rd, .trace_en, .pc_lo, .pc_hi,
        .report_valid, .report_tag, .report_pc, .report_instr, .report_result,
        .report_addr, .report_data, .report_rd, .report_stalls, .report_cycle,
        .retired_count
    );

endmodule

`default_nettype wire

//--- src/retire_reporter.sv
/* Retire report generator with enable and PC window filter,
   free-running cycle counter and retire counter */

`timescale 1ns/1ps
`default_nettype none

module retire_reporter #(
    parameter int ID_W = 4
) (
    input  wire logic                               clk,
    input  wire logic                               rst_n,
    input  wire logic                               wb_valid,
    input  wire logic [ID_W-1:0]                    wb_tag,
    // Record of the retiring instruction
    input  wire logic [trace_pkg::XLEN-1:0]         rec_pc,
    input  wire logic [trace_pkg::XLEN-1:0]         rec_instr,
    input  wire logic [trace_pkg::XLEN-1:0]         rec_result,
    input  wire logic [trace_pkg::XLEN-1:0]         rec_addr,
    input  wire logic [trace_pkg::STALL_W-1:0]      rec_stalls,
    // Write-back data straight from the CPU
    input  wire logic [trace_pkg::XLEN-1:0]         wb_data,
    input  wire logic [trace_pkg::RD_W-1:0]         wb_rd,
    // Filter settings
    input  wire logic                               trace_en,
    input  wire logic [trace_pkg::XLEN-1:0]         pc_lo,
    input  wire logic [trace_pkg::XLEN-1:0]         pc_hi,
    // Report strobe and fields
    output logic                                    report_valid,
    output logic      [ID_W-1:0]                    report_tag,
    output logic      [trace_pkg::XLEN-1:0]         report_pc,
    output logic      [trace_pkg::XLEN-1:0]         report_instr,
    output logic      [trace_pkg::XLEN-1:0]         report_result,
    output logic      [trace_pkg::XLEN-1:0]         report_addr,
    output logic      [trace_pkg::XLEN-1:0]         report_data,
    output logic      [trace_pkg::RD_W-1:0]         report_rd,
    output logic      [trace_pkg::STALL_W-1:0]      report_stalls,
    output logic      [trace_pkg::XLEN-1:0]         report_cycle,
    output logic      [trace_pkg::XLEN-1:0]         retired_count
);

    logic [trace_pkg::XLEN-1:0] cycle_cnt; // Zero in the first cycle after reset
    logic                       in_window;
    logic                       report_hit;

    // Inclusive PC window
    assign in_window  = (rec_pc >= pc_lo) && (rec_pc <= pc_hi);
    assign report_hit = wb_valid && trace_en && in_window;

    ////////////////////
    // Counters
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cycle_cnt     <= '0;
            retired_count <= '0;
            report_valid  <= 1'b0;
        end else begin
            cycle_cnt    <= cycle_cnt + 1'b1;
            report_valid <= report_hit;             // Strobe one cycle after write-back
            if (wb_valid) begin
                retired_count <= retired_count + 1'b1; // Counts filtered retirements too
            end
        end
    end

    ////////////////////
    // Report fields
    ////////////////////

    // Fields only change when a report goes out
    always_ff @(posedge clk) begin
        if (report_hit) begin
            report_tag    <= wb_tag;
            report_pc     <= rec_pc;
            report_instr  <= rec_instr;
            report_result <= rec_result;
            report_addr   <= rec_addr;
            report_data   <= wb_data;   // Sampled in the write-back cycle
            report_rd     <= wb_rd;
            report_stalls <= rec_stalls;
            report_cycle  <= cycle_cnt; // Write-back cycle number
        end
    end

endmodule

`default_nettype wire

//--- src/trace_config_regs.sv
/* Strobe-written configuration registers for
   trace enable and the PC window bounds */

`timescale 1ns/1ps
`default_nettype none

module trace_config_regs (
    input  wire logic                               clk,
    input  wire logic                               rst_n,
    input  wire logic                               cfg_wr,    // One-cycle write strobe
    input  wire logic [trace_pkg::CFG_ADDR_W-1:0]   cfg_addr,
    input  wire logic [trace_pkg::XLEN-1:0]         cfg_wdata,
    output logic                                    trace_en,
    output logic      [trace_pkg::XLEN-1:0]         pc_lo,     // Inclusive low bound
    output logic      [trace_pkg::XLEN-1:0]         pc_hi      // Inclusive high bound
);

    ////////////////////
    // Register writes
    ////////////////////

    // Reset opens the full window with tracing off
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            trace_en <= 1'b0;
            pc_lo    <= '0;
            pc_hi    <= '1;
        end else if (cfg_wr) begin
            case (cfg_addr)
                trace_pkg::CFG_CTRL: begin
                    trace_en <= cfg_wdata[0]; // Upper bits reserved
                end
                trace_pkg::CFG_PC_LO: begin
                    pc_lo <= cfg_wdata;
                end
                trace_pkg::CFG_PC_HI: begin
                    pc_hi <= cfg_wdata;
                end
                default: begin
                    // Unmapped address, write dropped
                end
            endcase
        end
    end

    // New values are visible the cycle after the strobe

endmodule

`default_nettype wire

//--- src/trace_record_store.sv
/* Per-tag trace record memory with stage field capture,
   saturating decode stall count and write-back read port */

`timescale 1ns/1ps
`default_nettype none

module trace_record_store #(
    parameter int ID_W = 4
) (
    input  wire logic                               clk,
    input  wire logic                               rst_n,
    input  wire logic                               stall,
    // Stage valids and tags from the tracker
    input  wire logic                               fetch_valid,
    input  wire logic                               decode_valid,
    input  wire logic                               exec_valid,
    input  wire logic                               mem_valid,
    input  wire logic                               wb_valid,
    input  wire logic [ID_W-1:0]                    fetch_tag,
    input  wire logic [ID_W-1:0]                    decode_tag,
    input  wire logic [ID_W-1:0]                    exec_tag,
    input  wire logic [ID_W-1:0]                    mem_tag,
    input  wire logic [ID_W-1:0]                    wb_tag,
    // Stage data from the CPU
    input  wire logic [trace_pkg::XLEN-1:0]         fetch_pc,
    input  wire logic [trace_pkg::XLEN-1:0]         decode_instr,
    input  wire logic [trace_pkg::XLEN-1:0]         exec_result,
    input  wire logic [trace_pkg::XLEN-1:0]         mem_addr,
    // Record of the retiring tag
    output logic      [trace_pkg::XLEN-1:0]         rec_pc,
    output logic      [trace_pkg::XLEN-1:0]         rec_instr,
    output logic      [trace_pkg::XLEN-1:0]         rec_result,
    output logic      [trace_pkg::XLEN-1:0]         rec_addr,
    output logic      [trace_pkg::STALL_W-1:0]      rec_stalls
);

    localparam int DEPTH = 2**ID_W; // One record per tag value

    // Record fields, one array per capturing stage
    logic [trace_pkg::XLEN-1:0]    pc_mem     [DEPTH];
    logic [trace_pkg::XLEN-1:0]    instr_mem  [DEPTH];
    logic [trace_pkg::XLEN-1:0]    result_mem [DEPTH];
    logic [trace_pkg::XLEN-1:0]    addr_mem   [DEPTH];
    logic [trace_pkg::STALL_W-1:0] stalls_mem [DEPTH];

    logic [trace_pkg::STALL_W-1:0] dec_stalls;     // Count so far for the decode instruction
    logic [trace_pkg::STALL_W-1:0] dec_stalls_nxt; // Count including this cycle

    ////////////////////
    // Decode stall count
    ////////////////////

    // Saturates at all ones
    always_comb begin
        dec_stalls_nxt = dec_stalls;
        if (stall && dec_stalls != {trace_pkg::STALL_W{1'b1}}) begin
            dec_stalls_nxt = dec_stalls + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_stalls <= '0;
        end else if (!stall) begin
            dec_stalls <= '0;             // Next instruction enters decode fresh
        end else if (decode_valid) begin
            dec_stalls <= dec_stalls_nxt; // Held in decode, one more cycle
        end
    end

    ////////////////////
    // Field capture
    ////////////////////

    // Held stages rewrite their field, so the last held cycle wins
    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            pc_mem[fetch_tag] <= fetch_pc;
        end
        if (decode_valid) begin
            instr_mem[decode_tag]  <= decode_instr;
            stalls_mem[decode_tag] <= dec_stalls_nxt;
        end
        if (exec_valid) begin
            result_mem[exec_tag] <= exec_result;
        end
        if (mem_valid) begin
            addr_mem[mem_tag] <= mem_addr;
        end
    end

    ////////////////////
    // Write-back read
    ////////////////////

    // Idle outputs read as zero
    assign rec_pc     = wb_valid ? pc_mem[wb_tag]     : '0;
    assign rec_instr  = wb_valid ? instr_mem[wb_tag]  : '0;
    assign rec_result = wb_valid ? result_mem[wb_tag] : '0;
    assign rec_addr   = wb_valid ? addr_mem[wb_tag]   : '0;
    assign rec_stalls = wb_valid ? stalls_mem[wb_tag] : '0;

endmodule

`default_nettype wire

//--- src/stage_tag_tracker.sv
/* Sequence tag generator and five-stage tag and valid
   pipeline with stall hold and execute bubble */

`timescale 1ns/1ps
`default_nettype none

module stage_tag_tracker #(
    parameter int ID_W = 4
) (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic            stall,        // CPU holds fetch and decode
    output logic                 fetch_valid,
    output logic                 decode_valid,
    output logic                 exec_valid,
    output logic                 mem_valid,
    output logic                 wb_valid,
    output logic [ID_W-1:0]      fetch_tag,
    output logic [ID_W-1:0]      decode_tag,
    output logic [ID_W-1:0]      exec_tag,
    output logic [ID_W-1:0]      mem_tag,
    output logic [ID_W-1:0]      wb_tag
);

    logic [ID_W-1:0] next_tag; // Tag handed to the next fetched instruction

    ////////////////////
    // Front stages
    ////////////////////

    // Fetch and decode advance only without stall
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            next_tag     <= '0;
            fetch_valid  <= 1'b0;
            fetch_tag    <= '0;
            decode_valid <= 1'b0;
            decode_tag   <= '0;
        end else if (!stall) begin
            fetch_valid  <= 1'b1;              // Fetch runs continuously
            fetch_tag    <= next_tag;
            next_tag     <= next_tag + 1'b1;   // Wraps at 2**ID_W
            decode_valid <= fetch_valid;
            decode_tag   <= fetch_tag;
        end
        // Stall: both front stages keep tag and valid
    end

    ////////////////////
    // Back stages
    ////////////////////

    // Execute, memory and write-back shift every cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exec_valid <= 1'b0;
            exec_tag   <= '0;
            mem_valid  <= 1'b0;
            mem_tag    <= '0;
            wb_valid   <= 1'b0;
            wb_tag     <= '0;
        end else begin
            exec_valid <= decode_valid & ~stall; // Bubble while decode is held
            exec_tag   <= decode_tag;            // Tag is don't-care under a bubble
            mem_valid  <= exec_valid;
            mem_tag    <= exec_tag;
            wb_valid   <= mem_valid;
            wb_tag     <= mem_tag;
        end
    end

    // At most five tags are live, so ID_W >= 3 never aliases a live record

endmodule

`default_nettype wire

//--- src/trace_pkg.sv
/* Shared widths and configuration register map
   for the pipeline trace unit */

`default_nettype none

package trace_pkg;

    ////////////////////
    // Data widths
    ////////////////////

    localparam int XLEN    = 32; // PC, instruction, result, address, data
    localparam int STALL_W = 4;  // Per-instruction decode stall counter
    localparam int RD_W    = 5;  // Destination register index

    ////////////////////
    // Config register map
    ////////////////////

    localparam int CFG_ADDR_W = 2;

    // Bit 0 of CFG_CTRL is trace enable
    localparam logic [CFG_ADDR_W-1:0] CFG_CTRL  = 2'd0;
    localparam logic [CFG_ADDR_W-1:0] CFG_PC_LO = 2'd1; // Window low bound, inclusive
    localparam logic [CFG_ADDR_W-1:0] CFG_PC_HI = 2'd2; // Window high bound, inclusive
    // Address 3 is unused, writes dropped

endpackage

`default_nettype wire
